// ==== async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo import fifo_cfg_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEFAULT_FIFO_DEPTH,
  parameter int FIFO_AFULL  = DEFAULT_AFULL,
  parameter int FIFO_AEMPTY = DEFAULT_AEMPTY
) (
  input  wire                  wr_clk,
  input  wire                  wr_rst_n,
  input  wire                  wr_en,
  input  wire [DATA_WIDTH-1:0] wr_data,
  input  wire                  rd_clk,
  input  wire                  rd_rst_n,
  input  wire                  rd_en,
  output wire [DATA_WIDTH-1:0] rd_data,
  output wire                  full,
  output wire                  afull,
  output wire                  empty,
  output wire                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  wire [ADDR_WIDTH:0] wr_ptr_gray; // crosses into rd_clk.
  wire [ADDR_WIDTH:0] rd_ptr_gray; // crosses into wr_clk.

  fifo_ram_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_bus ();

  async_fifo_wr_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .ram         (ram_bus.writer),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  dualport_ram_async #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .port     (ram_bus.ram)
  );

  async_fifo_rd_ctrl #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .ram         (ram_bus.reader),
    .rd_data     (rd_data),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

endmodule

`default_nettype wire

// ==== async_fifo_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo_rd_ctrl import gray_code_pkg::*; #(
  parameter  int DATA_WIDTH  = 8,
  parameter  int FIFO_DEPTH  = 16,
  parameter  int FIFO_AEMPTY = 2,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH)
) (
  input  wire                   rd_clk,
  input  wire                   rd_rst_n,
  input  wire                   rd_en,
  fifo_ram_if.reader            ram,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic [ADDR_WIDTH:0]   rd_ptr_gray,
  input  wire  [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic                  empty,
  output logic                  aempty
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [ADDR_WIDTH:0] AEMPTY_LVL = PTR_W'(FIFO_AEMPTY);

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_s1;
  logic [ADDR_WIDTH:0] wr_gray_s2;
  logic [ADDR_WIDTH:0] wr_ptr_sync;
  logic [ADDR_WIDTH:0] rd_used;
  logic                rd_vld;
  logic                empty_nxt;

  assign rd_vld      = rd_en & ~empty; // reads of an empty FIFO are ignored.
  assign rd_ptr_nxt  = rd_ptr + {{ADDR_WIDTH{1'b0}}, rd_vld};
  assign rd_gray_nxt = PTR_W'(bin_to_gray(GRAY_MAX_WIDTH'(rd_ptr_nxt)));
  assign wr_ptr_sync = PTR_W'(gray_to_bin(GRAY_MAX_WIDTH'(wr_gray_s2)));
  assign rd_used     = wr_ptr_sync - rd_ptr_nxt;
  assign empty_nxt   = (rd_gray_nxt == wr_gray_s2);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // two-flop synchronizer for the write pointer.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= (rd_used <= AEMPTY_LVL); // pessimistic, the write side lags.
    end
  end

  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr[ADDR_WIDTH-1:0];
  assign rd_data     = ram.rd_data;

  // no read may slip past the write pointer it sees.
  a_no_rd_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    PTR_W'(wr_ptr_sync - rd_ptr) <= FIFO_DEPTH
  );

  a_rd_gray_one_bit : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $onehot0(rd_ptr_gray ^ $past(rd_ptr_gray))
  );

endmodule

`default_nettype wire

// ==== async_fifo_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo_wr_ctrl import gray_code_pkg::*; #(
  parameter  int DATA_WIDTH = 8,
  parameter  int FIFO_DEPTH = 16,
  parameter  int FIFO_AFULL = 14,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  wire                   wr_clk,
  input  wire                   wr_rst_n,
  input  wire                   wr_en,
  input  wire  [DATA_WIDTH-1:0] wr_data,
  fifo_ram_if.writer            ram,
  output logic [ADDR_WIDTH:0]   wr_ptr_gray,
  input  wire  [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic                  full,
  output logic                  afull
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [ADDR_WIDTH:0] AFULL_LVL = PTR_W'(FIFO_AFULL);

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_s1;
  logic [ADDR_WIDTH:0] rd_gray_s2;
  logic [ADDR_WIDTH:0] rd_ptr_sync;
  logic [ADDR_WIDTH:0] wr_used;
  logic                wr_vld;
  logic                full_nxt;

  assign wr_vld      = wr_en & ~full; // writes into a full FIFO are dropped.
  assign wr_ptr_nxt  = wr_ptr + {{ADDR_WIDTH{1'b0}}, wr_vld};
  assign wr_gray_nxt = PTR_W'(bin_to_gray(GRAY_MAX_WIDTH'(wr_ptr_nxt)));
  assign rd_ptr_sync = PTR_W'(gray_to_bin(GRAY_MAX_WIDTH'(rd_gray_s2)));
  assign wr_used     = wr_ptr_nxt - rd_ptr_sync;

  // full when the pointers differ only in the wrap bit.
  assign full_nxt = (wr_gray_nxt ==
                     {~rd_gray_s2[ADDR_WIDTH -: 2], rd_gray_s2[ADDR_WIDTH-2:0]});

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt; // registered so only one bit moves.
    end
  end

  // two-flop synchronizer for the read pointer.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= (wr_used >= AFULL_LVL);
    end
  end

  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr[ADDR_WIDTH-1:0];
  assign ram.wr_data = wr_data;

  // write pointer never gets more than a depth ahead of the read side.
  a_no_wr_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    PTR_W'(wr_ptr - rd_ptr_sync) <= FIFO_DEPTH
  );

  // the crossing pointer must be safe for the remote synchronizer.
  a_wr_gray_one_bit : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $onehot0(wr_ptr_gray ^ $past(wr_ptr_gray))
  );

endmodule

`default_nettype wire

// ==== dualport_ram_async.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualport_ram_async #(
  parameter int DATA_WIDTH = 8,
  parameter int FIFO_DEPTH = 16
) (
  input wire      wr_clk,
  input wire      rd_clk,
  input wire      rd_rst_n,
  fifo_ram_if.ram port
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [DATA_WIDTH-1:0] rd_q;

  // write side, wr_clk domain.
  always_ff @(posedge wr_clk) begin
    if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // registered read, rd_clk domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_q <= '0;
    end else if (port.rd_en) begin
      rd_q <= mem[port.rd_addr]; // holds until the next read.
    end
  end

  assign port.rd_data = rd_q;

endmodule

`default_nettype wire

// ==== fifo_cfg_pkg.sv ====
`default_nettype none

package fifo_cfg_pkg;

  // width of one data word.
  parameter int DEFAULT_DATA_WIDTH = 8;

  // number of entries, must be a power of two.
  parameter int DEFAULT_FIFO_DEPTH = 16;

  // afull is set at or above this many stored words.
  parameter int DEFAULT_AFULL = DEFAULT_FIFO_DEPTH - 2;

  // aempty is set at or below this many stored words.
  parameter int DEFAULT_AEMPTY = 2;

endpackage

`default_nettype wire

// ==== fifo_ram_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface fifo_ram_if #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) ();

  logic                  wr_en;   // write strobe, already qualified by full.
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  logic                  rd_en;   // read strobe, already qualified by empty.
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data; // registered in the rd_clk domain.

  modport writer (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== gray_code_pkg.sv ====
`default_nettype none

package gray_code_pkg;

  // widest pointer the functions handle; callers zero-extend and truncate.
  parameter int GRAY_MAX_WIDTH = 32;

  function automatic logic [GRAY_MAX_WIDTH-1:0] bin_to_gray(
    input logic [GRAY_MAX_WIDTH-1:0] bin
  );
    return (bin >> 1) ^ bin; // zero upper bits stay zero.
  endfunction

  function automatic logic [GRAY_MAX_WIDTH-1:0] gray_to_bin(
    input logic [GRAY_MAX_WIDTH-1:0] gray
  );
    logic [GRAY_MAX_WIDTH-1:0] bin;
    bin[GRAY_MAX_WIDTH-1] = gray[GRAY_MAX_WIDTH-1];
    for (int i = GRAY_MAX_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the async FIFO testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_async_fifo \
  --Mdir obj_dir \
  -o sim_tb_async_fifo

./obj_dir/sim_tb_async_fifo | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi

// ==== sources.f ====
fifo_cfg_pkg.sv
gray_code_pkg.sv
fifo_ram_if.sv
dualport_ram_async.sv
async_fifo_wr_ctrl.sv
async_fifo_rd_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

// ==== tb_async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_async_fifo import fifo_cfg_pkg::*;;

  localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
  localparam int DEPTH          = DEFAULT_FIFO_DEPTH;
  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = 40 * DEPTH * NUM_TESTS; // wr_clk cycles.

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  wire  [DATA_WIDTH-1:0] rd_data;
  wire                   full;
  wire                   afull;
  wire                   empty;
  wire                   aempty;

  logic [DATA_WIDTH-1:0] sb_q [$]; // accepted words, oldest first.
  logic [31:0]           lfsr_state;
  string                 cur_test;
  int                    error_count;
  int                    err_at_start;
  int                    pass_count;
  int                    fail_count;
  int                    cycle_count;

  async_fifo uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  always #50 wr_clk = ~wr_clk;
  always #65 rd_clk = ~rd_clk; // drifts against wr_clk.

  always @(posedge wr_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d write clock cycles in test %s",
               cycle_count, cur_test);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output logic [DATA_WIDTH-1:0] w);
    for (int b = 0; b < DATA_WIDTH; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  task automatic check_word(input string what, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s: %s expected %0b, actual %0b", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("FAILED %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = error_count;
  endtask

  task automatic finish_test();
    if (error_count == err_at_start) begin
      $display("test %s: ok", cur_test);
      pass_count++;
    end else begin
      $display("test %s: %0d errors", cur_test, error_count - err_at_start);
      fail_count++;
    end
  endtask

  // both sides idle long enough for the pointers to cross.
  task automatic settle();
    repeat (10) @(posedge rd_clk);
    #5;
  endtask

  // a write counts when full was low as the strobe was driven.
  task automatic write_words(input int n);
    logic [DATA_WIDTH-1:0] w;
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      #5;
      draw_word(w);
      wr_en   = 1'b1;
      wr_data = w;
      if (!full) sb_q.push_back(w);
    end
    @(posedge wr_clk);
    #5;
    wr_en = 1'b0;
  endtask

  task automatic wait_not_empty();
    while (empty) begin
      @(posedge rd_clk);
      #5;
    end
  endtask

  task automatic compare_read();
    logic [DATA_WIDTH-1:0] exp;
    if (sb_q.size() == 0) begin
      $display("%s: DUT returned a word that was never written", cur_test);
      error_count++;
    end else begin
      exp = sb_q.pop_front();
      check_word("rd_data", exp, rd_data);
    end
  endtask

  // reads one word per rd_clk cycle until empty rises.
  task automatic drain(output int n_read);
    logic pending;
    pending = 1'b0;
    n_read  = 0;
    do begin
      @(posedge rd_clk);
      #5;
      if (pending) begin
        compare_read();
        n_read++;
      end
      pending = !empty;
      rd_en   = !empty;
    end while (pending);
  endtask

  task automatic test_reset();
    start_test("reset");
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    check_word("rd_data", '0, rd_data);
    finish_test();
  endtask

  task automatic test_in_order();
    int n;
    start_test("in_order");
    write_words(10);
    wait_not_empty();
    drain(n);
    check_count("words read", 10, n);
    finish_test();
  endtask

  task automatic test_overflow();
    int n;
    start_test("overflow");
    settle();
    write_words(DEPTH);
    check_flag("full after last free entry", 1'b1, full);
    write_words(3);
    check_count("words queued", DEPTH, sb_q.size());
    wait_not_empty();
    drain(n);
    check_count("words read", DEPTH, n);
    settle();
    check_flag("empty", 1'b1, empty);
    finish_test();
  endtask

  task automatic test_underflow();
    logic [DATA_WIDTH-1:0] prev;
    int n;
    start_test("underflow");
    settle();
    prev = rd_data;
    for (int k = 0; k < 5; k++) begin
      @(posedge rd_clk);
      #5;
      check_flag("empty", 1'b1, empty);
      check_word("rd_data held", prev, rd_data);
      rd_en = 1'b1;
    end
    @(posedge rd_clk);
    #5;
    rd_en = 1'b0;
    check_flag("empty", 1'b1, empty);
    check_word("rd_data held", prev, rd_data);
    write_words(1);
    wait_not_empty();
    drain(n);
    check_count("words read", 1, n);
    finish_test();
  endtask

  task automatic test_thresholds();
    int levels[5];
    int n;
    start_test("thresholds");
    levels[0] = 0;
    levels[1] = 2;
    levels[2] = 3;
    levels[3] = DEPTH - 2;
    levels[4] = DEPTH;
    settle();
    for (int i = 0; i < 5; i++) begin
      write_words(levels[i] - sb_q.size());
      settle();
      check_flag($sformatf("afull at %0d words", levels[i]),
                 levels[i] >= DEFAULT_AFULL, afull);
      check_flag($sformatf("aempty at %0d words", levels[i]),
                 levels[i] <= DEFAULT_AEMPTY, aempty);
    end
    drain(n);
    check_count("words read", DEPTH, n);
    finish_test();
  endtask

  task automatic test_streaming();
    logic [DATA_WIDTH-1:0] w;
    int total;
    int written;
    int issued;
    int checked;
    logic pending;
    start_test("streaming");
    total   = 3 * DEPTH; // wraps the pointers three times.
    written = 0;
    issued  = 0;
    checked = 0;
    pending = 1'b0;
    settle();
    fork
      begin
        while (written < total) begin
          @(posedge wr_clk);
          #5;
          if (!full) begin
            draw_word(w);
            wr_en   = 1'b1;
            wr_data = w;
            sb_q.push_back(w);
            written++;
          end else begin
            wr_en = 1'b0;
          end
        end
        @(posedge wr_clk);
        #5;
        wr_en = 1'b0;
      end
      begin
        while (checked < total) begin
          @(posedge rd_clk);
          #5;
          if (pending) begin
            compare_read();
            checked++;
          end
          pending = (issued < total) && !empty;
          rd_en   = pending;
          if (pending) issued++;
        end
      end
    join
    settle();
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    finish_test();
  endtask

  initial begin
    wr_clk      = 1'b0;
    rd_clk      = 1'b0;
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_en       = 1'b0;
    wr_data     = '0;
    rd_en       = 1'b0;
    lfsr_state  = 32'h4030cf6f;
    cur_test    = "startup";
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    cycle_count = 0;
    fork
      begin
        repeat (3) @(posedge wr_clk);
        #5 wr_rst_n = 1'b1;
      end
      begin
        repeat (3) @(posedge rd_clk);
        #5 rd_rst_n = 1'b1;
      end
    join
    test_reset();
    test_in_order();
    test_overflow();
    test_underflow();
    test_thresholds();
    test_streaming();
    $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
